// ==== design/butterfly.sv ====
// Pipelined radix-2 butterfly
`default_nettype none

module butterfly (
	input wire clk,
	input wire rst_n,
	input wire en,
	input wire fft_types_pkg::sample_t p_re,
	input wire fft_types_pkg::sample_t p_im,
	input wire fft_types_pkg::sample_t q_re,
	input wire fft_types_pkg::sample_t q_im,
	input wire fft_types_pkg::sample_t w_re,
	input wire fft_types_pkg::sample_t w_im,
	output wire valid,
	output wire fft_types_pkg::sample_t a_re,
	output wire fft_types_pkg::sample_t a_im,
	output wire fft_types_pkg::sample_t b_re,
	output wire fft_types_pkg::sample_t b_im
);

	localparam int FRAC = fft_twiddle_pkg::FRAC_BITS;
	localparam int MSB = fft_types_pkg::ACC_W - 1;
	localparam int HI = FRAC + fft_types_pkg::SAMPLE_W - 2;

	logic [2:0] en_d;

	fft_types_pkg::acc_t qw_rr, qw_ii, qw_ri, qw_ir;
	fft_types_pkg::acc_t p_re_s1, p_im_s1;
	fft_types_pkg::acc_t p_re_s2, p_im_s2;
	fft_types_pkg::acc_t qw_re, qw_im;
	fft_types_pkg::acc_t a_re_r, a_im_r, b_re_r, b_im_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_d <= '0;
		end else begin
			en_d <= {en_d[1:0], en};
		end
	end

	// partial products, p lifted to the twiddle scale
	always_ff @(posedge clk) begin
		if (en) begin
			qw_rr <= fft_types_pkg::acc_t'(q_re) * fft_types_pkg::acc_t'(w_re);
			qw_ii <= fft_types_pkg::acc_t'(q_im) * fft_types_pkg::acc_t'(w_im);
			qw_ri <= fft_types_pkg::acc_t'(q_re) * fft_types_pkg::acc_t'(w_im);
			qw_ir <= fft_types_pkg::acc_t'(q_im) * fft_types_pkg::acc_t'(w_re);
			p_re_s1 <= fft_types_pkg::acc_t'(p_re) <<< FRAC;
			p_im_s1 <= fft_types_pkg::acc_t'(p_im) <<< FRAC;
		end
	end

	// q * w
	always_ff @(posedge clk) begin
		if (en_d[0]) begin
			qw_re <= qw_rr - qw_ii;
			qw_im <= qw_ri + qw_ir;
			p_re_s2 <= p_re_s1;
			p_im_s2 <= p_im_s1;
		end
	end

	always_ff @(posedge clk) begin
		if (en_d[1]) begin
			a_re_r <= p_re_s2 + qw_re;
			a_im_r <= p_im_s2 + qw_im;
			b_re_r <= p_re_s2 - qw_re;
			b_im_r <= p_im_s2 - qw_im;
		end
	end

	// back to sample scale, sign kept
	assign a_re = {a_re_r[MSB], a_re_r[HI:FRAC]};
	assign a_im = {a_im_r[MSB], a_im_r[HI:FRAC]};
	assign b_re = {b_re_r[MSB], b_re_r[HI:FRAC]};
	assign b_im = {b_im_r[MSB], b_im_r[HI:FRAC]};
	assign valid = en_d[2];

	a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		en |-> ##3 valid);

endmodule

`default_nettype wire

// ==== design/fft_stage.sv ====
// One radix-2 FFT layer
`default_nettype none

module fft_stage #(
	parameter int LOG2_POINTS = 3,
	parameter int STAGE = 0,
	localparam int POINTS = 1 << LOG2_POINTS
) (
	input wire clk,
	input wire rst_n,
	input wire en,
	input wire fft_types_pkg::sample_t in_re [POINTS],
	input wire fft_types_pkg::sample_t in_im [POINTS],
	output wire fft_types_pkg::sample_t out_re [POINTS],
	output wire fft_types_pkg::sample_t out_im [POINTS],
	output wire valid
);

	// distance between p and q
	localparam int SPAN = 1 << STAGE;
	// table step for this frame size
	localparam int TW_SHIFT = fft_types_pkg::MAX_LOG2_POINTS - LOG2_POINTS;

	for (genvar b = 0; b < POINTS / 2; b++) begin : g_bfly
		localparam int J = b % SPAN;
		localparam int P = (b / SPAN) * 2 * SPAN + J;
		localparam int Q = P + SPAN;
		// exponent of W_N, then its slot in the 16-point table
		localparam int R = J << (LOG2_POINTS - 1 - STAGE);
		localparam int TW = R << TW_SHIFT;

		wire bfly_valid;

		butterfly u_bfly (
			.clk(clk),
			.rst_n(rst_n),
			.en(en),
			.p_re(in_re[P]),
			.p_im(in_im[P]),
			.q_re(in_re[Q]),
			.q_im(in_im[Q]),
			.w_re(fft_twiddle_pkg::twiddle_re[TW]),
			.w_im(fft_twiddle_pkg::twiddle_im[TW]),
			.valid(bfly_valid),
			.a_re(out_re[P]),
			.a_im(out_im[P]),
			.b_re(out_re[Q]),
			.b_im(out_im[Q])
		);

		// all units share timing, pair 0 speaks for the layer
		if (b == 0) begin : g_valid
			assign valid = bfly_valid;
		end
	end

endmodule

`default_nettype wire

// ==== design/fft_top.sv ====
// Parallel radix-2 FFT engine
`default_nettype none

module fft_top #(
	parameter int LOG2_POINTS = 3
) (
	input wire clk,
	input wire rst_n,
	input wire stb,
	input wire sop_in,
	input wire fft_types_pkg::sample_t x_re,
	input wire fft_types_pkg::sample_t x_im,
	output wire valid_out,
	output wire sop_out,
	output wire fft_types_pkg::sample_t y_re,
	output wire fft_types_pkg::sample_t y_im
);

	localparam int POINTS = 1 << LOG2_POINTS;

	// lane[0] is the reordered input, lane[s+1] the result of stage s
	wire fft_types_pkg::sample_t lane_re [LOG2_POINTS+1][POINTS];
	wire fft_types_pkg::sample_t lane_im [LOG2_POINTS+1][POINTS];
	wire [LOG2_POINTS:0] lane_en;

	sample_capture #(
		.LOG2_POINTS(LOG2_POINTS)
	) u_capture (
		.clk(clk),
		.rst_n(rst_n),
		.stb(stb),
		.sop_in(sop_in),
		.x_re(x_re),
		.x_im(x_im),
		.frame_re(lane_re[0]),
		.frame_im(lane_im[0]),
		.frame_en(lane_en[0])
	);

	for (genvar s = 0; s < LOG2_POINTS; s++) begin : g_stage
		fft_stage #(
			.LOG2_POINTS(LOG2_POINTS),
			.STAGE(s)
		) u_stage (
			.clk(clk),
			.rst_n(rst_n),
			.en(lane_en[s]),
			.in_re(lane_re[s]),
			.in_im(lane_im[s]),
			.out_re(lane_re[s+1]),
			.out_im(lane_im[s+1]),
			.valid(lane_en[s+1])
		);
	end

	output_serializer #(
		.LOG2_POINTS(LOG2_POINTS)
	) u_serializer (
		.clk(clk),
		.rst_n(rst_n),
		.load(lane_en[LOG2_POINTS]),
		.in_re(lane_re[LOG2_POINTS]),
		.in_im(lane_im[LOG2_POINTS]),
		.valid_out(valid_out),
		.sop_out(sop_out),
		.y_re(y_re),
		.y_im(y_im)
	);

endmodule

`default_nettype wire

// ==== design/fft_twiddle_pkg.sv ====
// FFT twiddle coefficients
`default_nettype none

package fft_twiddle_pkg;

	// twiddles in Q2.13, unity is 0x2000
	localparam int FRAC_BITS = 13;

	// half of the largest frame
	localparam int TWIDDLE_COUNT = 1 << (fft_types_pkg::MAX_LOG2_POINTS - 1);

	// cos(2 pi k / 16)
	localparam fft_types_pkg::sample_t twiddle_re [TWIDDLE_COUNT] = '{
		16'h2000,
		16'h1D90,
		16'h16A1,
		16'h0C3F,
		16'h0000,
		16'hF3C1,
		16'hE95F,
		16'hE270
	};

	// -sin(2 pi k / 16)
	localparam fft_types_pkg::sample_t twiddle_im [TWIDDLE_COUNT] = '{
		16'h0000,
		16'hF3C1,
		16'hE95F,
		16'hE270,
		16'hE000,
		16'hE270,
		16'hE95F,
		16'hF3C1
	};

endpackage

`default_nettype wire

// ==== design/fft_types_pkg.sv ====
// FFT data types
`default_nettype none

package fft_types_pkg;

	// one real or imaginary part
	localparam int SAMPLE_W = 16;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// butterfly products and sums
	localparam int ACC_W = 32;
	typedef logic signed [ACC_W-1:0] acc_t;

	// frame exponent range, 4 to 16 points
	localparam int MAX_LOG2_POINTS = 4;
	localparam int MIN_LOG2_POINTS = 2;

	// input frame counter
	typedef enum logic {
		CAP_IDLE,
		CAP_COLLECT
	} capture_state_t;

endpackage

`default_nettype wire

// ==== design/output_serializer.sv ====
// FFT output serializer
`default_nettype none

module output_serializer #(
	parameter int LOG2_POINTS = 3,
	localparam int POINTS = 1 << LOG2_POINTS
) (
	input wire clk,
	input wire rst_n,
	input wire load,
	input wire fft_types_pkg::sample_t in_re [POINTS],
	input wire fft_types_pkg::sample_t in_im [POINTS],
	output wire valid_out,
	output logic sop_out,
	output wire fft_types_pkg::sample_t y_re,
	output wire fft_types_pkg::sample_t y_im
);

	// samples still to be shown
	logic [LOG2_POINTS:0] cnt;

	fft_types_pkg::sample_t shreg_re [POINTS];
	fft_types_pkg::sample_t shreg_im [POINTS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			sop_out <= 1'b0;
			for (int k = 0; k < POINTS; k++) begin
				shreg_re[k] <= '0;
				shreg_im[k] <= '0;
			end
		end else if (load) begin
			cnt <= (LOG2_POINTS + 1)'(POINTS);
			sop_out <= 1'b1;
			for (int k = 0; k < POINTS; k++) begin
				shreg_re[k] <= in_re[k];
				shreg_im[k] <= in_im[k];
			end
		end else begin
			sop_out <= 1'b0;
			if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
			// bin 0 leaves first, zeros fill from the top
			for (int k = 0; k < POINTS - 1; k++) begin
				shreg_re[k] <= shreg_re[k+1];
				shreg_im[k] <= shreg_im[k+1];
			end
			shreg_re[POINTS-1] <= '0;
			shreg_im[POINTS-1] <= '0;
		end
	end

	assign valid_out = (cnt != '0);
	assign y_re = shreg_re[0];
	assign y_im = shreg_im[0];

	// a new frame may only replace the last sample of the old one
	a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
		load |-> !(valid_out && cnt > 1));

endmodule

`default_nettype wire

// ==== design/sample_capture.sv ====
// FFT input frame capture
`default_nettype none

module sample_capture #(
	parameter int LOG2_POINTS = 3,
	localparam int POINTS = 1 << LOG2_POINTS
) (
	input wire clk,
	input wire rst_n,
	input wire stb,
	input wire sop_in,
	input wire fft_types_pkg::sample_t x_re,
	input wire fft_types_pkg::sample_t x_im,
	output wire fft_types_pkg::sample_t frame_re [POINTS],
	output wire fft_types_pkg::sample_t frame_im [POINTS],
	output logic frame_en
);

	localparam logic [LOG2_POINTS-1:0] LAST = LOG2_POINTS'(POINTS - 1);

	fft_types_pkg::capture_state_t state;
	logic [LOG2_POINTS-1:0] cnt;

	// newest sample at index 0
	fft_types_pkg::sample_t shreg_re [POINTS];
	fft_types_pkg::sample_t shreg_im [POINTS];

	function automatic int bit_rev(input int v);
		int r;
		r = 0;
		for (int b = 0; b < LOG2_POINTS; b++) begin
			r = (r << 1) | ((v >> b) & 1);
		end
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (stb) begin
			shreg_re[0] <= x_re;
			shreg_im[0] <= x_im;
			for (int k = 1; k < POINTS; k++) begin
				shreg_re[k] <= shreg_re[k-1];
				shreg_im[k] <= shreg_im[k-1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= fft_types_pkg::CAP_IDLE;
			cnt <= '0;
			frame_en <= 1'b0;
		end else begin
			frame_en <= 1'b0;
			case (state)
				fft_types_pkg::CAP_IDLE: begin
					if (stb && sop_in) begin
						state <= fft_types_pkg::CAP_COLLECT;
						cnt <= LOG2_POINTS'(1);
					end
				end
				default: begin
					if (stb) begin
						// last sample closes the frame
						if (cnt == LAST) begin
							state <= fft_types_pkg::CAP_IDLE;
							frame_en <= 1'b1;
						end
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// sample n sits at POINTS-1-n, so output i takes sample bit_rev(i)
	for (genvar i = 0; i < POINTS; i++) begin : g_rev
		localparam int SRC = POINTS - 1 - bit_rev(i);
		assign frame_re[i] = shreg_re[SRC];
		assign frame_im[i] = shreg_im[SRC];
	end

	initial begin
		assert (LOG2_POINTS >= fft_types_pkg::MIN_LOG2_POINTS &&
			LOG2_POINTS <= fft_types_pkg::MAX_LOG2_POINTS)
			else $fatal(1, "frame size out of range");
	end

	a_no_sop_mid_frame: assert property (@(posedge clk) disable iff (!rst_n)
		state == fft_types_pkg::CAP_COLLECT |-> !(stb && sop_in));

endmodule

`default_nettype wire

// ==== fft_top.f ====
design/fft_types_pkg.sv
design/fft_twiddle_pkg.sv
design/butterfly.sv
design/fft_stage.sv
design/sample_capture.sv
design/output_serializer.sv
design/fft_top.sv
tests/fft_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the FFT testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fft_top_tb -f fft_top.f

sim_out=$(./obj_dir/Vfft_top_tb 2>&1) || true
echo "$sim_out"

if grep -qx "All tests passed" <<< "$sim_out"; then
	exit 0
fi
echo "simulation did not pass"
exit 1

// ==== tests/fft_frame_input.mem ====
// columns: input re, input im, expected re, expected im (hex, one line per point)
// frames: impulse, constant, random_a, random_b
1234 F800 1234 F800
0000 0000 1234 F800
0000 0000 1234 F800
0000 0000 1234 F800
0000 0000 1234 F800
0000 0000 1234 F800
0000 0000 1234 F800
0000 0000 1234 F800
0100 FF80 0800 FC00
0100 FF80 0000 0000
0100 FF80 0000 0000
0100 FF80 0000 0000
0100 FF80 0000 0000
0100 FF80 0000 0000
0100 FF80 0000 0000
0100 FF80 0000 0000
0064 FFCE 00BE 002D
FFE2 0046 004E 0022
00C8 000A FFE7 FF92
FF88 FFB0 FFC9 004B
003C 0028 017C 0005
000F FFA6 FFE3 FD03
FFB5 0019 005F 0014
0028 0078 00A4 0126
FF38 012C 0041 007D
0096 0000 FE9F 0110
FFF6 FF06 FE57 01C7
0050 005A FFBA 006E
0000 FF9C FEF7 FEF7
FFC4 0023 FE04 02FF
006E FFEC FF51 01E5
FFFB 0046 0081 01C1

// ==== tests/fft_top_tb.sv ====
// FFT engine testbench
`default_nettype none

module fft_top_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LOG2_POINTS = 3;
	localparam int POINTS = 1 << LOG2_POINTS;
	localparam int FRAMES = 4;
	localparam int TOTAL = FRAMES * POINTS;
	localparam int LATENCY = 3 * LOG2_POINTS + 2;
	localparam int TIMEOUT = 4 * (TOTAL + 3 * LOG2_POINTS + 40);

	logic clk;
	logic rst_n;
	logic stb;
	logic sop_in;
	fft_types_pkg::sample_t x_re;
	fft_types_pkg::sample_t x_im;
	wire valid_out;
	wire sop_out;
	wire fft_types_pkg::sample_t y_re;
	wire fft_types_pkg::sample_t y_im;

	// four words per point, see the data file
	logic [15:0] vectors [TOTAL*4];
	int last_drive [FRAMES];
	int frames_driven = 0;
	int out_count = 0;
	int cycle = 0;

	fft_top #(
		.LOG2_POINTS(LOG2_POINTS)
	) UUT (
		.clk(clk),
		.rst_n(rst_n),
		.stb(stb),
		.sop_in(sop_in),
		.x_re(x_re),
		.x_im(x_im),
		.valid_out(valid_out),
		.sop_out(sop_out),
		.y_re(y_re),
		.y_im(y_im)
	);

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_sample(input string name, input fft_types_pkg::sample_t expected,
		input fft_types_pkg::sample_t actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %0d actual %0d", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input bit expected, input bit actual);
		if (actual != expected) begin
			$display("** Error: %s expected %b actual %b", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("** Error: %s expected %0d actual %0d", name, expected, actual);
			stop_with_failure();
		end
	endtask

	function automatic string frame_name(input int f);
		case (f)
			0: return "impulse";
			1: return "constant";
			2: return "random_a";
			default: return "random_b";
		endcase
	endfunction

	// col 0/1 input, col 2/3 expected bin
	function automatic fft_types_pkg::sample_t stim_word(input int line, input int col);
		return fft_types_pkg::sample_t'(vectors[line * 4 + col]);
	endfunction

	// stb low with junk on the data lines
	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			stb = 1'b0;
			sop_in = 1'($urandom_range(0, 1));
			x_re = fft_types_pkg::sample_t'($urandom);
			x_im = fft_types_pkg::sample_t'($urandom);
		end
	endtask

	task automatic drive_frame(input int f, input int max_gap);
		for (int n = 0; n < POINTS; n++) begin
			if (n > 0 && max_gap > 0) begin
				drive_idle($urandom_range(0, max_gap));
			end
			@(negedge clk);
			stb = 1'b1;
			sop_in = (n == 0);
			x_re = stim_word(f * POINTS + n, 0);
			x_im = stim_word(f * POINTS + n, 1);
		end
		last_drive[f] = cycle;
		frames_driven++;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT) begin
			$display("timeout, output frames still missing after %0d cycles", TIMEOUT);
			stop_with_failure();
		end
	end

	// output side, sampled away from the rising edge
	always @(negedge clk) begin
		int f;
		int bin;
		f = out_count / POINTS;
		bin = out_count % POINTS;
		if (valid_out) begin
			if (out_count >= TOTAL) begin
				$display("valid_out is high after the last expected frame");
				stop_with_failure();
			end
			if (bin == 0 && f >= frames_driven) begin
				$display("valid_out rose before frame %s was fully driven", frame_name(f));
				stop_with_failure();
			end
			if (bin == 0) begin
				check_count({frame_name(f), " latency"}, LATENCY, cycle - last_drive[f]);
			end
			check_flag($sformatf("%s bin %0d sop_out", frame_name(f), bin), bin == 0, sop_out);
			check_sample($sformatf("%s bin %0d re", frame_name(f), bin),
				stim_word(f * POINTS + bin, 2), y_re);
			check_sample($sformatf("%s bin %0d im", frame_name(f), bin),
				stim_word(f * POINTS + bin, 3), y_im);
			out_count++;
		end else begin
			if (bin != 0) begin
				$display("valid_out dropped after %0d samples of frame %s", bin, frame_name(f));
				stop_with_failure();
			end
			check_flag("sop_out while idle", 1'b0, sop_out);
		end
	end

	initial begin
		void'($urandom(32'h4a75_c3c6));
		rst_n = 1'b0;
		stb = 1'b0;
		sop_in = 1'b0;
		x_re = '0;
		x_im = '0;
		$readmemh("tests/fft_frame_input.mem", vectors);
		repeat (5) @(negedge clk);
		check_flag("reset valid_out", 1'b0, valid_out);
		check_flag("reset sop_out", 1'b0, sop_out);
		check_sample("reset y_re", '0, y_re);
		check_sample("reset y_im", '0, y_im);
		rst_n = 1'b1;
		drive_idle(2);
		// impulse, then the constant frame with strobe gaps
		drive_frame(0, 0);
		drive_idle($urandom_range(1, 4));
		drive_frame(1, 3);
		drive_idle($urandom_range(1, 4));
		// random frames back to back
		drive_frame(2, 0);
		drive_frame(3, 0);
		drive_idle(1);
		wait (out_count == TOTAL);
		// quiet tail, any extra sample trips the monitor
		drive_idle(2 * POINTS);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
